//--- flist.f
logic/ns_msg_pkg.sv
logic/ns_route_pkg.sv
logic/msg_source.sv
logic/split_fsm.sv
logic/msg_sink.sv
logic/net_1to2_top.sv
verif/tb_net_1to2.sv

//--- logic/msg_sink.sv
`timescale 1ns/10ps
`default_nettype none

module msg_sink (
	input  wire logic                i_clk,
	input  wire logic                i_arst_n,
	input  wire logic                i_req,
	input  wire ns_msg_pkg::ns_msg_t i_msg,
	output logic                     o_ack,
	output ns_msg_pkg::data_t        o_ck_dat,
	output ns_msg_pkg::cnt_t         o_cnt,
	output logic                     o_err
);
	import ns_route_pkg::*;

	logic new_req;

	// A request that has not been acknowledged yet
	assign new_req = i_req && !o_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ack    <= 1'b0;
			o_ck_dat <= DATA_START;
			o_cnt    <= CNT_START;
			o_err    <= 1'b0;
		end else begin
			if (new_req) begin
				o_ack    <= 1'b1;
				o_ck_dat <= i_msg.dat;
				// Count wraps at its width
				o_cnt    <= o_cnt + 1'b1;
				// Sticky error unless data rises strictly
				if (i_msg.dat <= o_ck_dat) begin
					o_err <= 1'b1;
				end
			end else if (!i_req && o_ack) begin
				o_ack <= 1'b0;
			end
		end
	end

	// Request still held when the ack shows up
	a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_ack) |-> i_req)
		else $error("msg_sink: ack rose without a request");

endmodule

`default_nettype wire

//--- logic/msg_source.sv
`timescale 1ns/10ps
`default_nettype none

module msg_source (
	input  wire logic                i_clk,
	input  wire logic                i_arst_n,
	input  wire logic                i_start,
	input  wire ns_msg_pkg::cnt_t    i_burst_len,
	input  wire ns_msg_pkg::addr_t   i_dst_lo,
	input  wire ns_msg_pkg::addr_t   i_dst_hi,
	output logic                     o_req,
	output ns_msg_pkg::ns_msg_t      o_msg,
	input  wire logic                i_ack,
	output logic                     o_busy,
	output logic                     o_done
);
	import ns_msg_pkg::*;
	import ns_route_pkg::*;

	addr_t lo_r;
	addr_t hi_r;
	cnt_t  left_r;
	logic  arm_r;
	addr_t dst_nxt;

	// Sweep wraps from the high bound back to the low bound
	assign dst_nxt = (o_msg.dst >= hi_r) ? lo_r : addr_t'(o_msg.dst + 1'b1);

	// Bounds held for the whole burst
	always_ff @(posedge i_clk) begin
		if (!o_busy && i_start) begin
			lo_r <= i_dst_lo;
			hi_r <= i_dst_hi;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_req     <= 1'b0;
			o_busy    <= 1'b0;
			o_done    <= 1'b0;
			arm_r     <= 1'b0;
			left_r    <= '0;
			o_msg.dst <= '0;
			o_msg.dat <= DATA_START;
		end else begin
			o_done <= 1'b0;
			if (!o_busy) begin
				if (i_start) begin
					if (i_burst_len == '0) begin
						o_done <= 1'b1;
					end else begin
						o_busy <= 1'b1;
						arm_r  <= 1'b1;
						left_r <= i_burst_len;
					end
				end
			end else if (arm_r) begin
				// First message of the burst
				arm_r     <= 1'b0;
				o_req     <= 1'b1;
				o_msg.dst <= lo_r;
				o_msg.dat <= o_msg.dat + 1'b1;
			end else if (o_req) begin
				if (i_ack) begin
					o_req <= 1'b0;
				end
			end else if (!i_ack) begin
				// Ack has fallen, either finish or launch the next one
				if (left_r == cnt_t'(1)) begin
					o_busy <= 1'b0;
					o_done <= 1'b1;
				end else begin
					left_r    <= left_r - 1'b1;
					o_req     <= 1'b1;
					o_msg.dst <= dst_nxt;
					o_msg.dat <= o_msg.dat + 1'b1;
				end
			end
		end
	end

	// Payload must not move while a request is pending
	a_msg_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_req && $past(o_req)) |-> $stable(o_msg))
		else $error("msg_source: message changed while request high");

endmodule

`default_nettype wire

//--- logic/net_1to2_top.sv
`timescale 1ns/10ps
`default_nettype none

module net_1to2_top (
	input  wire logic              i_clk,
	input  wire logic              i_arst_n,
	input  wire logic              i_start,
	input  wire ns_msg_pkg::cnt_t  i_burst_len,
	input  wire ns_msg_pkg::addr_t i_dst_lo,
	input  wire ns_msg_pkg::addr_t i_dst_hi,
	input  wire ns_msg_pkg::addr_t i_route_ref,
	output logic                   o_busy,
	output logic                   o_done,
	output ns_msg_pkg::data_t      o_0_ck_dat,
	output ns_msg_pkg::cnt_t       o_0_cnt,
	output logic                   o_0_err,
	output ns_msg_pkg::data_t      o_1_ck_dat,
	output ns_msg_pkg::cnt_t       o_1_cnt,
	output logic                   o_1_err
);
	import ns_msg_pkg::*;

	// Source to splitter
	logic    src_req;
	ns_msg_t src_msg;
	logic    src_ack;

	// Splitter to sinks
	logic    s0_req;
	ns_msg_t s0_msg;
	logic    s0_ack;
	logic    s1_req;
	ns_msg_t s1_msg;
	logic    s1_ack;

	msg_source u_source (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(i_start),
		.i_burst_len(i_burst_len), .i_dst_lo(i_dst_lo), .i_dst_hi(i_dst_hi),
		.o_req(src_req), .o_msg(src_msg), .i_ack(src_ack),
		.o_busy(o_busy), .o_done(o_done)
	);

	split_fsm u_split (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_route_ref(i_route_ref),
		.i_req(src_req), .i_msg(src_msg), .o_ack(src_ack),
		.o_0_req(s0_req), .o_0_msg(s0_msg), .i_0_ack(s0_ack),
		.o_1_req(s1_req), .o_1_msg(s1_msg), .i_1_ack(s1_ack)
	);

	msg_sink u_sink_0 (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_req(s0_req), .i_msg(s0_msg), .o_ack(s0_ack),
		.o_ck_dat(o_0_ck_dat), .o_cnt(o_0_cnt), .o_err(o_0_err)
	);

	msg_sink u_sink_1 (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_req(s1_req), .i_msg(s1_msg), .o_ack(s1_ack),
		.o_ck_dat(o_1_ck_dat), .o_cnt(o_1_cnt), .o_err(o_1_err)
	);

endmodule

`default_nettype wire

//--- logic/ns_msg_pkg.sv
`default_nettype none

package ns_msg_pkg;

	// Field widths of a message and of the burst counters
	localparam int ADDR_W = 6;
	localparam int DATA_W = 16;
	localparam int CNT_W  = 8;

	// Destination address of a message
	typedef logic [ADDR_W-1:0] addr_t;

	// Payload word
	typedef logic [DATA_W-1:0] data_t;

	// Burst length or accepted-message count
	typedef logic [CNT_W-1:0] cnt_t;

	// One message on a channel, destination in the upper bits
	typedef struct packed {
		addr_t dst;
		data_t dat;
	} ns_msg_t;

endpackage

`default_nettype wire

//--- logic/ns_route_pkg.sv
`default_nettype none

package ns_route_pkg;

	// Splitter handshake phases
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		FWD       = 2'd1,
		WAIT_DROP = 2'd2,
		RELEASE   = 2'd3
	} split_state_t;

	// Selected splitter output
	typedef logic port_sel_t;

	localparam port_sel_t PORT_0 = 1'b0;
	localparam port_sel_t PORT_1 = 1'b1;

	// Values after reset
	localparam ns_msg_pkg::data_t DATA_START = '0;
	localparam ns_msg_pkg::cnt_t  CNT_START  = '0;

endpackage

`default_nettype wire

//--- logic/split_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module split_fsm (
	input  wire logic                i_clk,
	input  wire logic                i_arst_n,
	input  wire ns_msg_pkg::addr_t   i_route_ref,
	input  wire logic                i_req,
	input  wire ns_msg_pkg::ns_msg_t i_msg,
	output logic                     o_ack,
	output logic                     o_0_req,
	output ns_msg_pkg::ns_msg_t      o_0_msg,
	input  wire logic                i_0_ack,
	output logic                     o_1_req,
	output ns_msg_pkg::ns_msg_t      o_1_msg,
	input  wire logic                i_1_ack
);
	import ns_msg_pkg::*;
	import ns_route_pkg::*;

	split_state_t state_r;
	port_sel_t    sel_r;
	port_sel_t    sel_in;
	ns_msg_t      msg_r;
	logic         sel_ack;

	// Above the threshold goes to output 1
	assign sel_in  = (i_msg.dst > i_route_ref) ? PORT_1 : PORT_0;
	assign sel_ack = (sel_r == PORT_1) ? i_1_ack : i_0_ack;

	// Both outputs carry the latched message, only one request is raised
	assign o_0_msg = msg_r;
	assign o_1_msg = msg_r;

	always_ff @(posedge i_clk) begin
		if (state_r == IDLE && i_req) begin
			msg_r <= i_msg;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= IDLE;
			sel_r   <= PORT_0;
			o_ack   <= 1'b0;
			o_0_req <= 1'b0;
			o_1_req <= 1'b0;
		end else begin
			unique case (state_r)
				IDLE: begin
					if (i_req) begin
						sel_r   <= sel_in;
						o_0_req <= (sel_in == PORT_0);
						o_1_req <= (sel_in == PORT_1);
						state_r <= FWD;
					end
				end
				FWD: begin
					// Pass the downstream ack back upstream
					if (sel_ack) begin
						o_ack   <= 1'b1;
						state_r <= WAIT_DROP;
					end
				end
				WAIT_DROP: begin
					if (!i_req) begin
						o_0_req <= 1'b0;
						o_1_req <= 1'b0;
						state_r <= RELEASE;
					end
				end
				RELEASE: begin
					// Upstream may start again once both acks are low
					if (!sel_ack) begin
						o_ack   <= 1'b0;
						state_r <= IDLE;
					end
				end
				default: begin
					state_r <= IDLE;
				end
			endcase
		end
	end

	a_one_port: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_0_req && o_1_req))
		else $error("split_fsm: both output requests high");

	// Upstream ack only follows a downstream ack
	a_ack_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_ack) |-> sel_ack)
		else $error("split_fsm: input ack rose without output ack");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_net_1to2 -f flist.f
./obj_dir/Vtb_net_1to2 > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
exit 0

//--- verif/tb_net_1to2.sv
`timescale 1ns/10ps
`default_nettype none

module tb_net_1to2;
	import ns_msg_pkg::*;
	import ns_route_pkg::*;

	// One stimulus row, kick requests an extra start while busy
	typedef struct packed {
		cnt_t  len;
		addr_t lo;
		addr_t hi;
		addr_t thr;
		logic  kick;
	} row_t;

	logic  i_clk;
	logic  i_arst_n;
	logic  i_start;
	cnt_t  i_burst_len;
	addr_t i_dst_lo;
	addr_t i_dst_hi;
	addr_t i_route_ref;
	logic  o_busy;
	logic  o_done;
	data_t o_0_ck_dat;
	cnt_t  o_0_cnt;
	logic  o_0_err;
	data_t o_1_ck_dat;
	cnt_t  o_1_cnt;
	logic  o_1_err;

	row_t  rows[$];
	string names[$];
	logic  table_ready;
	int    seed;

	// Reference model state, carried across bursts
	data_t model_dat;
	data_t exp_dat0;
	data_t exp_dat1;
	cnt_t  exp_cnt0;
	cnt_t  exp_cnt1;

	net_1to2_top u_dut (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(i_start),
		.i_burst_len(i_burst_len), .i_dst_lo(i_dst_lo), .i_dst_hi(i_dst_hi),
		.i_route_ref(i_route_ref), .o_busy(o_busy), .o_done(o_done),
		.o_0_ck_dat(o_0_ck_dat), .o_0_cnt(o_0_cnt), .o_0_err(o_0_err),
		.o_1_ck_dat(o_1_ck_dat), .o_1_cnt(o_1_cnt), .o_1_err(o_1_err)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input string what, input data_t exp,
			input data_t act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s %s: expected %0d, actual %0d", name, what, exp, act));
		end
	endtask

	task automatic check_cnt(input string name, input string what, input cnt_t exp,
			input cnt_t act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s %s: expected %0d, actual %0d", name, what, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
			input logic act);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s %s: expected %b, actual %b", name, what, exp, act));
		end
	endtask

	task automatic add_row(input string name, input cnt_t len, input addr_t lo,
			input addr_t hi, input addr_t thr, input logic kick);
		row_t r;
		r.len  = len;
		r.lo   = lo;
		r.hi   = hi;
		r.thr  = thr;
		r.kick = kick;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_random_rows(input int n);
		cnt_t  len;
		addr_t a;
		addr_t b;
		addr_t thr;
		for (int k = 0; k < n; k++) begin
			len = cnt_t'(1 + ($unsigned($random(seed)) % 20));
			a   = addr_t'($random(seed));
			b   = addr_t'($random(seed));
			thr = addr_t'($random(seed));
			// Low bound never above the high bound
			if (a > b) begin
				add_row($sformatf("random_%0d", k), len, b, a, thr, 1'b0);
			end else begin
				add_row($sformatf("random_%0d", k), len, a, b, thr, 1'b0);
			end
		end
	endtask

	// Sweep, count and route every message of one burst
	task automatic model_burst(input row_t r);
		addr_t dst;
		dst = r.lo;
		for (int i = 0; i < int'(r.len); i++) begin
			if (i == 0 || dst == r.hi) begin
				dst = r.lo;
			end else begin
				dst = dst + addr_t'(1);
			end
			model_dat = model_dat + data_t'(1);
			if (dst > r.thr) begin
				exp_cnt1 = exp_cnt1 + cnt_t'(1);
				exp_dat1 = model_dat;
			end else begin
				exp_cnt0 = exp_cnt0 + cnt_t'(1);
				exp_dat0 = model_dat;
			end
		end
	endtask

	task automatic run_row(input int idx);
		row_t  r;
		string name;
		r    = rows[idx];
		name = names[idx];
		@(negedge i_clk);
		i_burst_len = r.len;
		i_dst_lo    = r.lo;
		i_dst_hi    = r.hi;
		i_route_ref = r.thr;
		i_start     = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
		if (r.kick) begin
			// Second start mid-burst with another length
			repeat (3) @(negedge i_clk);
			check_flag(name, "o_busy at extra start", 1'b1, o_busy);
			i_burst_len = r.len + cnt_t'(5);
			i_start     = 1'b1;
			@(negedge i_clk);
			i_start     = 1'b0;
			i_burst_len = r.len;
		end
		while (!o_done) begin
			@(negedge i_clk);
		end
		check_flag(name, "o_busy at done", 1'b0, o_busy);
		model_burst(r);
		check_cnt(name, "sink 0 count", exp_cnt0, o_0_cnt);
		check_cnt(name, "sink 1 count", exp_cnt1, o_1_cnt);
		check_data(name, "sink 0 last data", exp_dat0, o_0_ck_dat);
		check_data(name, "sink 1 last data", exp_dat1, o_1_ck_dat);
		check_flag(name, "sink 0 error", 1'b0, o_0_err);
		check_flag(name, "sink 1 error", 1'b0, o_1_err);
		@(negedge i_clk);
		check_flag(name, "o_done after pulse", 1'b0, o_done);
	endtask

	// Budget grows with the total number of messages
	initial begin
		int unsigned  limit;
		split_state_t hang_state;
		limit = 200;
		wait (table_ready);
		foreach (rows[k]) begin
			limit += 12 * rows[k].len;
		end
		repeat (limit) @(posedge i_clk);
		hang_state = u_dut.u_split.state_r;
		abort_run($sformatf("Watchdog expired after %0d cycles, the run hung in splitter state %s",
			limit, hang_state.name()));
	end

	initial begin
		seed        = 54187;
		table_ready = 1'b0;
		i_arst_n    = 1'b0;
		i_start     = 1'b0;
		i_burst_len = '0;
		i_dst_lo    = '0;
		i_dst_hi    = '0;
		i_route_ref = '0;
		model_dat   = DATA_START;
		exp_dat0    = DATA_START;
		exp_dat1    = DATA_START;
		exp_cnt0    = '0;
		exp_cnt1    = '0;
		add_row("straddle", 8'd10, 6'd4, 6'd12, 6'd8, 1'b0);
		add_row("wrap_sweep", 8'd20, 6'd30, 6'd35, 6'd32, 1'b0);
		add_row("all_to_sink0", 8'd7, 6'd10, 6'd20, 6'd20, 1'b0);
		add_row("all_to_sink1", 8'd6, 6'd20, 6'd40, 6'd19, 1'b0);
		add_row("start_while_busy", 8'd6, 6'd0, 6'd63, 6'd2, 1'b1);
		add_row("zero_length", 8'd0, 6'd5, 6'd9, 6'd7, 1'b0);
		add_row("single_addr", 8'd4, 6'd63, 6'd63, 6'd62, 1'b0);
		build_random_rows(6);
		table_ready = 1'b1;
		repeat (4) @(negedge i_clk);
		i_arst_n = 1'b1;
		@(negedge i_clk);
		check_flag("after_reset", "o_busy", 1'b0, o_busy);
		check_flag("after_reset", "o_done", 1'b0, o_done);
		check_flag("after_reset", "sink 0 error", 1'b0, o_0_err);
		check_flag("after_reset", "sink 1 error", 1'b0, o_1_err);
		check_cnt("after_reset", "sink 0 count", '0, o_0_cnt);
		check_cnt("after_reset", "sink 1 count", '0, o_1_cnt);
		check_data("after_reset", "sink 0 last data", DATA_START, o_0_ck_dat);
		check_data("after_reset", "sink 1 last data", DATA_START, o_1_ck_dat);
		for (int k = 0; k < rows.size(); k++) begin
			run_row(k);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
